// File: rtl/rv_core_pkg.sv
// shared constants and instruction layout for the rv32i arithmetic datapath, no loads, stores or branches
package rv_core_pkg;

    // datapath and instruction width
    localparam int XLEN      = 32;
    // index field width in the instruction word, also with fewer registers
    localparam int REG_IDX_W = 5;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate

    // funct3 codes
    localparam logic [2:0] F3_ADD  = 3'b000; // add / sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl / sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct7 alternate form, picks sub and sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // alu operation codes
    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd9;

    // one instruction word seen as r-type or i-type
    // rs1, rd, funct3 and opcode sit at the same bits in both views
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [REG_IDX_W-1:0] rs2;
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } r;
        struct packed {
            logic [11:0]          imm12;  // sign bit at 11
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } i;
    } inst_u;

endpackage

// File: rtl/reg_file.sv
// register file, two async reads and one write on the clock edge, x0 reads as zero, REG_COUNT a power of two
`timescale 1ns/1ns

module reg_file #(
    parameter int REG_COUNT = 32
) (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              wen_i,
    input  logic [$clog2(REG_COUNT)-1:0]      waddr_i,
    input  logic [rv_core_pkg::XLEN-1:0]      wdata_i,
    input  logic [$clog2(REG_COUNT)-1:0]      raddr1_i,
    input  logic [$clog2(REG_COUNT)-1:0]      raddr2_i,
    output logic [rv_core_pkg::XLEN-1:0]      rdata1_o,
    output logic [rv_core_pkg::XLEN-1:0]      rdata2_o
);

    import rv_core_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    // write side, whole file cleared on reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int idx = 0; idx < REG_COUNT; idx++) begin
                regs[idx] <= '0;
            end
        end else if (wen_i) begin
            regs[waddr_i] <= wdata_i; // rd zero never arrives here
        end
    end

    // read ports, same-cycle write is not bypassed here
    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else begin
            rdata1_o = regs[raddr1_i];
        end
    end

    always_comb begin
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else begin
            rdata2_o = regs[raddr2_i];
        end
    end

endmodule

// File: rtl/decode_stage.sv
// decode for rv32i op and op-imm only, other opcodes pass as non-writing bubbles, fully combinational
`timescale 1ns/1ns

module decode_stage #(
    parameter int REG_COUNT = 32
) (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  inst_valid_i,
    input  rv_core_pkg::inst_u                    inst_i,
    input  logic [rv_core_pkg::XLEN-1:0]          alu_res_i,
    input  logic                                  ex_wen_i,
    input  logic [rv_core_pkg::REG_IDX_W-1:0]     ex_rd_i,
    input  logic                                  wb_en_i,
    input  logic [$clog2(REG_COUNT)-1:0]          wb_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]          wb_data_i,
    output logic                                  dec_valid_o,
    output logic                                  dec_wen_o,
    output logic [rv_core_pkg::REG_IDX_W-1:0]     dec_rd_o,
    output logic [rv_core_pkg::ALU_OP_W-1:0]      dec_alu_op_o,
    output logic [rv_core_pkg::XLEN-1:0]          dec_op_a_o,
    output logic [rv_core_pkg::XLEN-1:0]          dec_op_b_o
);

    import rv_core_pkg::*;

    localparam int ADDR_W = $clog2(REG_COUNT);

    logic              is_op;
    logic              is_op_imm;
    logic              is_shift;
    logic              sub_sel;
    logic              sra_sel;
    logic [ADDR_W-1:0] rs1_idx;
    logic [ADDR_W-1:0] rs2_idx;
    logic [ADDR_W-1:0] rd_idx;
    logic [XLEN-1:0]   rf_rdata1;
    logic [XLEN-1:0]   rf_rdata2;
    logic [XLEN-1:0]   rs1_val;
    logic [XLEN-1:0]   rs2_val;
    logic [XLEN-1:0]   imm_val;

    // upper index bit dropped when fewer registers
    assign rs1_idx = inst_i.r.rs1[ADDR_W-1:0];
    assign rs2_idx = inst_i.r.rs2[ADDR_W-1:0];
    assign rd_idx  = inst_i.i.rd[ADDR_W-1:0];

    assign is_op     = (inst_i.r.opcode == OPC_OP);
    assign is_op_imm = (inst_i.i.opcode == OPC_OP_IMM);
    assign is_shift  = (inst_i.i.funct3 == F3_SLL) || (inst_i.i.funct3 == F3_SR);

    assign sub_sel = is_op && (inst_i.r.funct7 == F7_ALT);
    // srai carries its alternate bit inside imm12
    assign sra_sel = is_op ? (inst_i.r.funct7 == F7_ALT) : inst_i.i.imm12[10];

    reg_file #(
        .REG_COUNT (REG_COUNT)
    ) u_reg_file (
        .clk      (clk),
        .rst_i    (rst_i),
        .wen_i    (wb_en_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (rs1_idx),
        .raddr2_i (rs2_idx),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    // execute result wins over write-back, file only when neither matches
    function automatic logic [XLEN-1:0] fwd_src(input logic [ADDR_W-1:0] idx,
                                               input logic [XLEN-1:0]   rf_val);
        logic hit_ex;
        logic hit_wb;
        hit_ex = ex_wen_i && (ex_rd_i[ADDR_W-1:0] == idx) && (idx != '0);
        hit_wb = wb_en_i && (wb_addr_i == idx) && (idx != '0);
        if (hit_ex) begin
            return alu_res_i;
        end else if (hit_wb) begin
            return wb_data_i;
        end
        return rf_val;
    endfunction

    always_comb begin
        rs1_val = fwd_src(rs1_idx, rf_rdata1);
        rs2_val = fwd_src(rs2_idx, rf_rdata2);
    end

    // shamt lives in imm12[4:0]
    always_comb begin
        if (is_shift) begin
            imm_val = XLEN'(inst_i.i.imm12[4:0]);
        end else begin
            imm_val = {{(XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
        end
    end

    always_comb begin
        case (inst_i.r.funct3)
            F3_ADD:  dec_alu_op_o = sub_sel ? ALU_SUB : ALU_ADD;
            F3_SLL:  dec_alu_op_o = ALU_SLL;
            F3_SLT:  dec_alu_op_o = ALU_SLT;
            F3_SLTU: dec_alu_op_o = ALU_SLTU;
            F3_XOR:  dec_alu_op_o = ALU_XOR;
            F3_SR:   dec_alu_op_o = sra_sel ? ALU_SRA : ALU_SRL;
            F3_OR:   dec_alu_op_o = ALU_OR;
            default: dec_alu_op_o = ALU_AND;
        endcase
    end

    assign dec_valid_o = inst_valid_i;
    assign dec_wen_o   = inst_valid_i && (is_op || is_op_imm) && (rd_idx != '0);
    assign dec_rd_o    = REG_IDX_W'(rd_idx);
    assign dec_op_a_o  = rs1_val;
    assign dec_op_b_o  = is_op ? rs2_val : imm_val; // operand b after imm mux

endmodule

// File: rtl/id_ex_reg.sv
// decode to execute pipeline register, never stalls, an idle cycle becomes a bubble
`timescale 1ns/1ns

module id_ex_reg (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  dec_valid_i,
    input  logic                                  dec_wen_i,
    input  logic [rv_core_pkg::REG_IDX_W-1:0]     dec_rd_i,
    input  logic [rv_core_pkg::ALU_OP_W-1:0]      dec_alu_op_i,
    input  logic [rv_core_pkg::XLEN-1:0]          dec_op_a_i,
    input  logic [rv_core_pkg::XLEN-1:0]          dec_op_b_i,
    output logic                                  ex_valid_o,
    output logic                                  ex_wen_o,
    output logic [rv_core_pkg::REG_IDX_W-1:0]     ex_rd_o,
    output logic [rv_core_pkg::ALU_OP_W-1:0]      ex_alu_op_o,
    output logic [rv_core_pkg::XLEN-1:0]          ex_op_a_o,
    output logic [rv_core_pkg::XLEN-1:0]          ex_op_b_o
);

    import rv_core_pkg::*;

    logic [REG_IDX_W-1:0] rd_q;
    logic [ALU_OP_W-1:0]  alu_op_q;
    logic [XLEN-1:0]      op_a_q;
    logic [XLEN-1:0]      op_b_q;

    // control flags, low during reset and for bubbles
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_o <= 1'b0;
            ex_wen_o   <= 1'b0;
        end else begin
            ex_valid_o <= dec_valid_i;
            ex_wen_o   <= dec_valid_i & dec_wen_i;
        end
    end

    // payload only moves with a real instruction
    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            rd_q     <= dec_rd_i;
            alu_op_q <= dec_alu_op_i;
            op_a_q   <= dec_op_a_i;
            op_b_q   <= dec_op_b_i;
        end
    end

    assign ex_rd_o     = rd_q;
    assign ex_alu_op_o = alu_op_q;
    assign ex_op_a_o   = op_a_q;
    assign ex_op_b_o   = op_b_q;

endmodule

// File: rtl/execute_stage.sv
// single-cycle alu and write-back registers, shifts use operand b[4:0], alu_res is combinational
`timescale 1ns/1ns

module execute_stage #(
    parameter int REG_COUNT = 32
) (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  ex_valid_i,
    input  logic                                  ex_wen_i,
    input  logic [rv_core_pkg::REG_IDX_W-1:0]     ex_rd_i,
    input  logic [rv_core_pkg::ALU_OP_W-1:0]      ex_alu_op_i,
    input  logic [rv_core_pkg::XLEN-1:0]          ex_op_a_i,
    input  logic [rv_core_pkg::XLEN-1:0]          ex_op_b_i,
    output logic [rv_core_pkg::XLEN-1:0]          alu_res_o,
    output logic                                  wb_en_o,
    output logic [$clog2(REG_COUNT)-1:0]          wb_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]          wb_data_o
);

    import rv_core_pkg::*;

    localparam int ADDR_W = $clog2(REG_COUNT);

    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;
    logic [XLEN-1:0] alu_res;

    assign shamt       = ex_op_b_i[4:0]; // amounts above 31 wrap
    assign lt_signed   = $signed(ex_op_a_i) < $signed(ex_op_b_i);
    assign lt_unsigned = ex_op_a_i < ex_op_b_i;

    always_comb begin
        case (ex_alu_op_i)
            ALU_ADD: begin
                alu_res = ex_op_a_i + ex_op_b_i;
            end
            ALU_SUB: begin
                alu_res = ex_op_a_i - ex_op_b_i;
            end
            ALU_AND: begin
                alu_res = ex_op_a_i & ex_op_b_i;
            end
            ALU_OR: begin
                alu_res = ex_op_a_i | ex_op_b_i;
            end
            ALU_XOR: begin
                alu_res = ex_op_a_i ^ ex_op_b_i;
            end
            ALU_SLT: begin
                alu_res = XLEN'(lt_signed);
            end
            ALU_SLTU: begin
                alu_res = XLEN'(lt_unsigned);
            end
            ALU_SLL: begin
                alu_res = ex_op_a_i << shamt;
            end
            ALU_SRL: begin
                alu_res = ex_op_a_i >> shamt;
            end
            ALU_SRA: begin
                alu_res = XLEN'($signed(ex_op_a_i) >>> shamt); // sign fill
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    // also the first forwarding source back into decode
    assign alu_res_o = alu_res;

    // write strobe, one pulse per register write
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= ex_valid_i & ex_wen_i;
        end
    end

    // result and target held until the next write
    always_ff @(posedge clk) begin
        if (ex_wen_i) begin
            wb_addr_o <= ex_rd_i[ADDR_W-1:0];
            wb_data_o <= alu_res;
        end
    end

endmodule

// File: rtl/rv_core.sv
// top of the arithmetic pipeline, no stall or back-pressure, write-back two edges after capture
`timescale 1ns/1ns

module rv_core #(
    parameter int REG_COUNT = 32 // 16 for an rv32e-style file
) (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  inst_valid_i,
    input  rv_core_pkg::inst_u                    inst_i,
    output logic                                  wb_en_o,
    output logic [$clog2(REG_COUNT)-1:0]          wb_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]          wb_data_o
);

    import rv_core_pkg::*;

    // decode outputs
    logic                 dec_valid;
    logic                 dec_wen;
    logic [REG_IDX_W-1:0] dec_rd;
    logic [ALU_OP_W-1:0]  dec_alu_op;
    logic [XLEN-1:0]      dec_op_a;
    logic [XLEN-1:0]      dec_op_b;

    // execute inputs
    logic                 ex_valid;
    logic                 ex_wen;
    logic [REG_IDX_W-1:0] ex_rd;
    logic [ALU_OP_W-1:0]  ex_alu_op;
    logic [XLEN-1:0]      ex_op_a;
    logic [XLEN-1:0]      ex_op_b;

    logic [XLEN-1:0]      alu_res; // forwarded back to decode

    decode_stage #(
        .REG_COUNT (REG_COUNT)
    ) u_decode_stage (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .alu_res_i    (alu_res),
        .ex_wen_i     (ex_wen),
        .ex_rd_i      (ex_rd),
        .wb_en_i      (wb_en_o),
        .wb_addr_i    (wb_addr_o),
        .wb_data_i    (wb_data_o),
        .dec_valid_o  (dec_valid),
        .dec_wen_o    (dec_wen),
        .dec_rd_o     (dec_rd),
        .dec_alu_op_o (dec_alu_op),
        .dec_op_a_o   (dec_op_a),
        .dec_op_b_o   (dec_op_b)
    );

    id_ex_reg u_id_ex_reg (
        .clk          (clk),
        .rst_i        (rst_i),
        .dec_valid_i  (dec_valid),
        .dec_wen_i    (dec_wen),
        .dec_rd_i     (dec_rd),
        .dec_alu_op_i (dec_alu_op),
        .dec_op_a_i   (dec_op_a),
        .dec_op_b_i   (dec_op_b),
        .ex_valid_o   (ex_valid),
        .ex_wen_o     (ex_wen),
        .ex_rd_o      (ex_rd),
        .ex_alu_op_o  (ex_alu_op),
        .ex_op_a_o    (ex_op_a),
        .ex_op_b_o    (ex_op_b)
    );

    execute_stage #(
        .REG_COUNT (REG_COUNT)
    ) u_execute_stage (
        .clk         (clk),
        .rst_i       (rst_i),
        .ex_valid_i  (ex_valid),
        .ex_wen_i    (ex_wen),
        .ex_rd_i     (ex_rd),
        .ex_alu_op_i (ex_alu_op),
        .ex_op_a_i   (ex_op_a),
        .ex_op_b_i   (ex_op_b),
        .alu_res_o   (alu_res),
        .wb_en_o     (wb_en_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

// File: dv/rv_core_properties.sv
// write-back timing checks for the non-stalling pipeline, one write two cycles after a valid instruction
`timescale 1ns/1ns

module rv_core_properties #(
    parameter int REG_COUNT = 32
) (
    input logic                         clk,
    input logic                         rst_i,
    input logic                         inst_valid_i,
    input logic                         wb_en_o,
    input logic [$clog2(REG_COUNT)-1:0] wb_addr_o
);

    // every write traces back to a valid instruction
    wb_has_source: assert property (@(posedge clk) disable iff (rst_i)
        wb_en_o |-> $past(inst_valid_i, 2))
        else $error("write-back without a valid instruction two cycles earlier");

    // first strobe computed from the cleared id/ex flags
    wb_quiet_after_reset: assert property (@(posedge clk) $fell(rst_i) |=> !wb_en_o)
        else $error("write-back pulse in the first cycle after reset");

    // x0 never written
    wb_addr_nonzero: assert property (@(posedge clk) disable iff (rst_i)
        wb_en_o |-> (wb_addr_o != '0))
        else $error("write-back to register zero");

endmodule

bind rv_core rv_core_properties #(
    .REG_COUNT (REG_COUNT)
) u_properties (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .wb_en_o      (wb_en_o),
    .wb_addr_o    (wb_addr_o)
);

// File: dv/rv_core_tb.sv
// assumes REG_COUNT 32 and write-back two edges after an instruction is driven, no random stimulus
`timescale 1ns/1ns

module rv_core_tb;

    import rv_core_pkg::*;

    localparam int REG_COUNT = 32;
    localparam int ADDR_W    = $clog2(REG_COUNT);

    logic              clk;
    logic              rst_i;
    logic              inst_valid_i;
    inst_u             inst_i;
    logic              wb_en_o;
    logic [ADDR_W-1:0] wb_addr_o;
    logic [XLEN-1:0]   wb_data_o;

    // stimulus table, one entry per cycle
    int              tab_test[$];
    logic [XLEN-1:0] tab_inst[$];
    bit              tab_valid[$];
    bit              tab_wen[$];
    logic [4:0]      tab_rd[$];
    logic [XLEN-1:0] tab_val[$];

    int errors    = 0;
    int test_errs = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int pipe0     = -1; // entry driven one edge ago
    int pipe1     = -1; // entry whose write-back is on the port now
    bit table_ready = 1'b0;

    rv_core #(
        .REG_COUNT (REG_COUNT)
    ) i_dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [XLEN-1:0] enc_r(logic [2:0] f3, logic [6:0] f7, logic [4:0] rd,
                                               logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [XLEN-1:0] enc_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                               logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    task automatic push_entry(int t, logic [XLEN-1:0] inst, bit valid, bit wen,
                              logic [4:0] rd, logic [XLEN-1:0] val);
        tab_test.push_back(t);
        tab_inst.push_back(inst);
        tab_valid.push_back(valid);
        tab_wen.push_back(wen);
        tab_rd.push_back(rd);
        tab_val.push_back(val);
    endtask

    task automatic expect_write(int t, logic [XLEN-1:0] inst, logic [4:0] rd,
                                logic [XLEN-1:0] val);
        push_entry(t, inst, 1'b1, 1'b1, rd, val);
    endtask

    task automatic expect_silent(int t, logic [XLEN-1:0] inst);
        push_entry(t, inst, 1'b1, 1'b0, 5'd0, '0);
    endtask

    task automatic insert_bubble(int t);
        push_entry(t, '0, 1'b0, 1'b0, 5'd0, '0);
    endtask

    // expected values follow sequential rv32i semantics
    task automatic build_table();
        insert_bubble(1);
        insert_bubble(1);
        expect_write(2, enc_i(F3_ADD, 1, 0, 12'h123), 1, 32'h0000_0123);
        expect_write(2, enc_i(F3_ADD, 2, 0, 12'hfff), 2, 32'hffff_ffff);  // -1
        expect_write(2, enc_i(F3_ADD, 3, 0, 12'h800), 3, 32'hffff_f800);  // -2048
        insert_bubble(2);
        insert_bubble(2);
        expect_write(2, enc_i(F3_AND, 4, 1, 12'h0f0), 4, 32'h0000_0020);
        expect_write(2, enc_i(F3_OR, 5, 1, 12'h700), 5, 32'h0000_0723);
        expect_write(2, enc_i(F3_XOR, 6, 2, 12'h555), 6, 32'hffff_faaa);
        expect_write(2, enc_i(F3_SLT, 7, 3, 12'd5), 7, 32'd1);   // -2048 < 5
        expect_write(2, enc_i(F3_SLTU, 8, 3, 12'd5), 8, 32'd0);  // huge unsigned
        expect_write(3, enc_i(F3_ADD, 10, 0, 12'd35), 10, 32'd35); // shift 35 masks to 3
        expect_write(3, enc_r(F3_ADD, 7'h00, 11, 1, 3), 11, 32'hffff_f923);
        expect_write(3, enc_r(F3_ADD, F7_ALT, 12, 1, 3), 12, 32'h0000_0923);
        expect_write(3, enc_r(F3_AND, 7'h00, 13, 2, 1), 13, 32'h0000_0123);
        expect_write(3, enc_r(F3_OR, 7'h00, 14, 1, 3), 14, 32'hffff_f923);
        expect_write(3, enc_r(F3_XOR, 7'h00, 15, 3, 2), 15, 32'h0000_07ff);
        expect_write(3, enc_r(F3_SLT, 7'h00, 16, 3, 1), 16, 32'd1);
        expect_write(3, enc_r(F3_SLTU, 7'h00, 17, 3, 1), 17, 32'd0);
        expect_write(3, enc_r(F3_SLL, 7'h00, 18, 1, 10), 18, 32'h0000_0918);
        expect_write(3, enc_r(F3_SR, 7'h00, 19, 3, 10), 19, 32'h1fff_ff00);
        expect_write(3, enc_r(F3_SR, F7_ALT, 20, 3, 10), 20, 32'hffff_ff00);
        expect_write(3, enc_i(F3_SLL, 21, 1, 12'd4), 21, 32'h0000_1230);
        expect_write(3, enc_i(F3_SR, 22, 3, 12'd8), 22, 32'h00ff_fff8);
        expect_write(3, enc_i(F3_SR, 23, 3, 12'h408), 23, 32'hffff_fff8); // srai
        // x24 chain hits both forwarding sources at once
        expect_write(4, enc_i(F3_ADD, 24, 0, 12'd5), 24, 32'd5);
        expect_write(4, enc_i(F3_ADD, 24, 24, 12'd7), 24, 32'd12);
        expect_write(4, enc_i(F3_ADD, 24, 24, 12'd1), 24, 32'd13);
        expect_write(4, enc_i(F3_SLL, 25, 24, 12'd2), 25, 32'd52);
        expect_write(4, enc_r(F3_ADD, F7_ALT, 26, 25, 24), 26, 32'd39);
        expect_write(4, enc_i(F3_ADD, 27, 0, 12'd100), 27, 32'd100);
        expect_write(4, enc_i(F3_ADD, 28, 0, 12'd3), 28, 32'd3);
        expect_write(4, enc_r(F3_ADD, 7'h00, 29, 27, 0), 29, 32'd100);
        expect_write(4, enc_r(F3_XOR, 7'h00, 30, 28, 27), 30, 32'h0000_0067);
        expect_write(4, enc_i(F3_ADD, 31, 0, 12'h555), 31, 32'h0000_0555);
        insert_bubble(4);
        insert_bubble(4);
        expect_write(4, enc_r(F3_OR, 7'h00, 9, 31, 24), 9, 32'h0000_055d);
        expect_silent(5, enc_i(F3_ADD, 0, 0, 12'h07f));
        expect_write(5, enc_r(F3_ADD, 7'h00, 22, 0, 0), 22, 32'd0);
        expect_silent(5, 32'h0010_8283); // load opcode, rd x5
        expect_silent(5, enc_r(F3_ADD, 7'h00, 0, 1, 2));
        insert_bubble(5);
        insert_bubble(5);
        expect_write(5, enc_r(F3_ADD, 7'h00, 21, 0, 5), 21, 32'h0000_0723);
        expect_write(6, enc_i(F3_ADD, 1, 0, 12'd1), 1, 32'd1);
        insert_bubble(6);
        expect_write(6, enc_i(F3_ADD, 2, 1, 12'd1), 2, 32'd2);
        expect_write(6, enc_i(F3_ADD, 3, 2, 12'd1), 3, 32'd3);
        insert_bubble(6);
        expect_write(6, enc_r(F3_ADD, 7'h00, 4, 3, 2), 4, 32'd5);
    endtask

    task automatic check_entry(int idx);
        bit last;
        if (idx < 0) begin
            if (wb_en_o !== 1'b0) begin
                $display("unexpected write pulse at %0t ns with no instruction due", $time);
                errors++;
            end
            return;
        end
        if (tab_wen[idx]) begin
            if (wb_en_o !== 1'b1) begin
                $display("missing write-back at %0t ns for test %0d entry %0d",
                         $time, tab_test[idx], idx);
                test_errs++;
            end else if (wb_addr_o !== tab_rd[idx] || wb_data_o !== tab_val[idx]) begin
                $display("ERROR at %0t ns: test %0d entry %0d wrote x%0d = %h, expected x%0d = %h",
                         $time, tab_test[idx], idx, wb_addr_o, wb_data_o, tab_rd[idx],
                         tab_val[idx]);
                test_errs++;
            end
        end else if (wb_en_o !== 1'b0) begin
            $display("unexpected write pulse at %0t ns for test %0d entry %0d",
                     $time, tab_test[idx], idx);
            test_errs++;
        end
        last = (idx == tab_test.size() - 1) || (tab_test[idx + 1] != tab_test[idx]);
        if (last) begin
            tests_run++;
            if (test_errs == 0) begin
                $display("test %0d passed", tab_test[idx]);
            end else begin
                $display("test %0d FAILED with %0d errors", tab_test[idx], test_errs);
                tests_bad++;
            end
            errors += test_errs;
            test_errs = 0;
        end
    endtask

    always @(negedge clk) begin
        if (rst_i && wb_en_o !== 1'b0) begin
            $display("write pulse seen at %0t ns while reset is high", $time);
            errors++;
        end
    end

    initial begin
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        // two extra cycles drain the pipe
        for (int i = 0; i < tab_inst.size() + 2; i++) begin
            @(posedge clk);
            if (i < tab_inst.size()) begin
                inst_valid_i <= tab_valid[i];
                inst_i       <= tab_inst[i];
            end else begin
                inst_valid_i <= 1'b0;
                inst_i       <= '0;
            end
            @(negedge clk);
            check_entry(pipe1);
            pipe1 = pipe0;
            pipe0 = (i < tab_inst.size()) ? i : -1;
        end
        $display("summary: %0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready);
        #((tab_inst.size() + 10) * 10);
        $display("timeout: write-back checks did not finish in time");
        $display("tests failed");
        $finish;
    end

endmodule

// File: filelist.f
rtl/rv_core_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/id_ex_reg.sv
rtl/execute_stage.sv
rtl/rv_core.sv
dv/rv_core_properties.sv
dv/rv_core_tb.sv
